//--- hw/capture_pkg.sv
// Shared types and constants for the capture buffer; depth must stay a power of two matching the address width
package capture_pkg;

    localparam int CAPTURE_ADDR_BITS = 5;   // Write and read address width of both memories
    localparam int CAPTURE_DEPTH     = 32;  // Entries stored before the capture stops
    localparam int DATA_BITS         = 64;  // Eight lanes of one byte each
    localparam int CTRL_BITS         = 8;   // One control flag per lane

    localparam int AXIL_ADDR_BITS    = 8;   // Enough for every register offset and the error range
    localparam int AXIL_DATA_BITS    = 32;

    // One decoded word as seen after the 64b/66b decoder
    typedef struct packed {
        logic [DATA_BITS-1:0] data;  // Lane 0 sits in the low byte
        logic [CTRL_BITS-1:0] ctrl;  // A set bit marks its lane as a control character
    } xgmii_word_t;

    // Software settings for the next capture
    typedef struct packed {
        logic       trig_enable;  // Wait for trig_char in lane 0 before storing
        logic [7:0] trig_char;
    } capture_cfg_t;

    // State reported back through REG_STATUS
    typedef struct packed {
        logic                       armed;  // Waiting for the trigger or writing
        logic                       full;
        logic [CAPTURE_ADDR_BITS:0] count;  // Holds up to CAPTURE_DEPTH inclusive
    } capture_status_t;

    // Register map, byte offsets
    localparam logic [AXIL_ADDR_BITS-1:0] REG_CTRL    = 8'h00;  // Bit 0 arm pulse, bit 1 trig_enable
    localparam logic [AXIL_ADDR_BITS-1:0] REG_TRIG    = 8'h04;
    localparam logic [AXIL_ADDR_BITS-1:0] REG_STATUS  = 8'h08;  // Read-only
    localparam logic [AXIL_ADDR_BITS-1:0] REG_INDEX   = 8'h0C;
    localparam logic [AXIL_ADDR_BITS-1:0] REG_DATA_LO = 8'h10;
    localparam logic [AXIL_ADDR_BITS-1:0] REG_DATA_HI = 8'h14;
    localparam logic [AXIL_ADDR_BITS-1:0] REG_CTRL_RD = 8'h18;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- hw/capture_bram.sv
// Simple dual-port memory without reset; stored contents are undefined until written
`timescale 1ns/1ps

module capture_bram
    import capture_pkg::*;
#(
    parameter type payload_t = logic [7:0]
)
(
    input  logic                         i_clock,
    input  logic                         i_write_enable,
    input  logic [CAPTURE_ADDR_BITS-1:0] i_write_addr,
    input  logic                         i_read_enable,
    input  logic [CAPTURE_ADDR_BITS-1:0] i_read_addr,
    input  payload_t                     i_data,
    output payload_t                     o_data
);

    payload_t mem [CAPTURE_DEPTH];  // Sized so it maps onto one block memory
    payload_t read_q;

    always_ff @(posedge i_clock)
    begin
        if (i_write_enable)
        begin
            mem[i_write_addr] <= i_data;
        end
    end

    // The read register keeps its last value while the port is disabled
    always_ff @(posedge i_clock)
    begin
        if (i_read_enable)
        begin
            read_q <= mem[i_read_addr];
        end
    end

    assign o_data = read_q;

endmodule

//--- hw/trigger_match.sv
// Matches only lane 0 with its control flag set; the hit comes one cycle after the matching word
`timescale 1ns/1ps

module trigger_match
    import capture_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_reset,
    input  xgmii_word_t i_word,
    input  logic        i_valid,
    input  logic [7:0]  i_trig_char,
    output logic        o_hit
);

    logic lane0_is_ctrl;
    logic lane0_match;
    logic hit_q;

    assign lane0_is_ctrl = i_word.ctrl[0];                  // Data bytes never trigger
    assign lane0_match   = (i_word.data[7:0] == i_trig_char);

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            hit_q <= 1'b0;
        end
        else
        begin
            hit_q <= i_valid && lane0_is_ctrl && lane0_match;  // Single-cycle pulse per matching word
        end
    end

    assign o_hit = hit_q;

endmodule

//--- hw/capture_control.sv
// Stores CAPTURE_DEPTH valid words then stops; an arm pulse restarts at any time and nothing wraps
`timescale 1ns/1ps

module capture_control
    import capture_pkg::*;
(
    input  logic                         i_clock,
    input  logic                         i_reset,
    input  logic                         i_arm,
    input  logic                         i_trig_enable,
    input  logic                         i_trig_hit,
    input  xgmii_word_t                  i_word,
    input  logic                         i_valid,
    input  logic [CAPTURE_ADDR_BITS-1:0] i_read_index,
    output xgmii_word_t                  o_entry,
    output capture_status_t              o_status
);

    typedef enum logic [1:0] {ST_IDLE, ST_WAIT_TRIG, ST_WRITING, ST_FULL} state_t;

    state_t                       state;
    xgmii_word_t                  word_q;
    logic                         valid_q;
    logic [CAPTURE_ADDR_BITS:0]   count;
    logic [CAPTURE_ADDR_BITS-1:0] write_addr;
    logic                         write_enable;
    logic                         read_enable;
    logic [DATA_BITS-1:0]         data_rd;
    logic [CTRL_BITS-1:0]         ctrl_rd;

    // One stage of delay so the stored word lines up with the trigger hit
    always_ff @(posedge i_clock)
    begin
        word_q <= i_word;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= i_valid && !i_arm;  // The word beside the arm pulse is never stored
        end
    end

    assign write_enable = valid_q &&
                          ((state == ST_WRITING) || ((state == ST_WAIT_TRIG) && i_trig_hit));
    assign write_addr   = count[CAPTURE_ADDR_BITS-1:0];  // Both memories share this address
    assign read_enable  = (state == ST_FULL);            // Readback only once the capture is done

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state <= ST_IDLE;
            count <= '0;
        end
        else if (i_arm)
        begin
            count <= '0;                                    // Restarts even a running capture
            state <= i_trig_enable ? ST_WAIT_TRIG : ST_WRITING;
        end
        else if (write_enable)
        begin
            count <= count + 1'b1;
            state <= (count == CAPTURE_DEPTH - 1) ? ST_FULL : ST_WRITING;
        end
    end

    assign o_status.armed = (state == ST_WAIT_TRIG) || (state == ST_WRITING);
    assign o_status.full  = (state == ST_FULL);
    assign o_status.count = count;

    capture_bram #(.payload_t(logic [DATA_BITS-1:0])) u_data_bram (
        .i_clock        (i_clock),
        .i_write_enable (write_enable),
        .i_write_addr   (write_addr),
        .i_read_enable  (read_enable),
        .i_read_addr    (i_read_index),
        .i_data         (word_q.data),
        .o_data         (data_rd)
    );

    capture_bram #(.payload_t(logic [CTRL_BITS-1:0])) u_ctrl_bram (
        .i_clock        (i_clock),
        .i_write_enable (write_enable),
        .i_write_addr   (write_addr),
        .i_read_enable  (read_enable),
        .i_read_addr    (i_read_index),
        .i_data         (word_q.ctrl),
        .o_data         (ctrl_rd)
    );

    assign o_entry.data = data_rd;
    assign o_entry.ctrl = ctrl_rd;

endmodule

//--- hw/axil_capture_regs.sv
// AXI4-Lite slave with one outstanding write and one outstanding read; only byte lane 0 is writable
`timescale 1ns/1ps

module axil_capture_regs
    import capture_pkg::*;
(
    input  logic                         i_clock,
    input  logic                         i_reset,
    input  logic [AXIL_ADDR_BITS-1:0]    i_axil_awaddr,
    input  logic                         i_axil_awvalid,
    output logic                         o_axil_awready,
    input  logic [AXIL_DATA_BITS-1:0]    i_axil_wdata,
    input  logic [AXIL_DATA_BITS/8-1:0]  i_axil_wstrb,
    input  logic                         i_axil_wvalid,
    output logic                         o_axil_wready,
    output logic [1:0]                   o_axil_bresp,
    output logic                         o_axil_bvalid,
    input  logic                         i_axil_bready,
    input  logic [AXIL_ADDR_BITS-1:0]    i_axil_araddr,
    input  logic                         i_axil_arvalid,
    output logic                         o_axil_arready,
    output logic [AXIL_DATA_BITS-1:0]    o_axil_rdata,
    output logic [1:0]                   o_axil_rresp,
    output logic                         o_axil_rvalid,
    input  logic                         i_axil_rready,
    output capture_cfg_t                 o_cfg,
    output logic                         o_arm,
    output logic [CAPTURE_ADDR_BITS-1:0] o_read_index,
    input  capture_status_t              i_status,
    input  xgmii_word_t                  i_entry
);

    capture_cfg_t                 cfg;
    logic                         arm_pulse;
    logic [CAPTURE_ADDR_BITS-1:0] read_index;
    logic                         write_fire;
    logic                         read_fire;
    logic                         bvalid;
    logic                         rvalid;
    logic [1:0]                   bresp;
    logic [1:0]                   rresp;
    logic [AXIL_DATA_BITS-1:0]    rdata;
    logic [AXIL_DATA_BITS-1:0]    rdata_next;

    // Every offset of the map, readable or not, answers OKAY
    function automatic logic offset_known(input logic [AXIL_ADDR_BITS-1:0] offset);
        case (offset)
            REG_CTRL, REG_TRIG, REG_STATUS, REG_INDEX,
            REG_DATA_LO, REG_DATA_HI, REG_CTRL_RD: return 1'b1;
            default:                               return 1'b0;
        endcase
    endfunction

    assign write_fire     = i_axil_awvalid && i_axil_wvalid && !bvalid;  // Address and data together
    assign read_fire      = i_axil_arvalid && !rvalid;
    assign o_axil_awready = write_fire;
    assign o_axil_wready  = write_fire;
    assign o_axil_arready = !rvalid;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            cfg        <= '0;
            arm_pulse  <= 1'b0;
            read_index <= '0;
            bvalid     <= 1'b0;
        end
        else
        begin
            arm_pulse <= 1'b0;  // Arm lasts one cycle only
            if (write_fire)
            begin
                bvalid <= 1'b1;
                if (i_axil_wstrb[0])
                begin
                    case (i_axil_awaddr)
                        REG_CTRL:
                        begin
                            arm_pulse       <= i_axil_wdata[0];
                            cfg.trig_enable <= i_axil_wdata[1];
                        end
                        REG_TRIG:  cfg.trig_char <= i_axil_wdata[7:0];
                        REG_INDEX: read_index    <= i_axil_wdata[CAPTURE_ADDR_BITS-1:0];
                        default:   ;  // Read-only and unknown offsets keep all settings
                    endcase
                end
            end
            else if (i_axil_bready)
            begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (write_fire)
        begin
            bresp <= offset_known(i_axil_awaddr) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Read data selection, the arm bit always reads back as zero
    always_comb
    begin
        rdata_next = '0;
        case (i_axil_araddr)
            REG_CTRL:    rdata_next[1]                           = cfg.trig_enable;
            REG_TRIG:    rdata_next[7:0]                         = cfg.trig_char;
            REG_STATUS:  rdata_next[$bits(capture_status_t)-1:0] = i_status;
            REG_INDEX:   rdata_next[CAPTURE_ADDR_BITS-1:0]       = read_index;
            REG_DATA_LO: rdata_next                              = i_entry.data[31:0];
            REG_DATA_HI: rdata_next                              = i_entry.data[63:32];
            REG_CTRL_RD: rdata_next[CTRL_BITS-1:0]               = i_entry.ctrl;
            default:     rdata_next                              = '0;
        endcase
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            rvalid <= 1'b0;
        end
        else if (read_fire)
        begin
            rvalid <= 1'b1;
        end
        else if (i_axil_rready)
        begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (read_fire)
        begin
            rdata <= rdata_next;
            rresp <= offset_known(i_axil_araddr) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign o_axil_bvalid = bvalid;
    assign o_axil_bresp  = bresp;
    assign o_axil_rvalid = rvalid;
    assign o_axil_rdata  = rdata;
    assign o_axil_rresp  = rresp;
    assign o_cfg         = cfg;
    assign o_arm         = arm_pulse;
    assign o_read_index  = read_index;

endmodule

//--- hw/xgmii_capture_top.sv
// Receive-side capture tap; the stream is only observed, so there is no ready back to the decoder
`timescale 1ns/1ps

module xgmii_capture_top
    import capture_pkg::*;
(
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  xgmii_word_t                 i_rx_word,
    input  logic                        i_rx_valid,
    input  logic [AXIL_ADDR_BITS-1:0]   i_axil_awaddr,
    input  logic                        i_axil_awvalid,
    output logic                        o_axil_awready,
    input  logic [AXIL_DATA_BITS-1:0]   i_axil_wdata,
    input  logic [AXIL_DATA_BITS/8-1:0] i_axil_wstrb,
    input  logic                        i_axil_wvalid,
    output logic                        o_axil_wready,
    output logic [1:0]                  o_axil_bresp,
    output logic                        o_axil_bvalid,
    input  logic                        i_axil_bready,
    input  logic [AXIL_ADDR_BITS-1:0]   i_axil_araddr,
    input  logic                        i_axil_arvalid,
    output logic                        o_axil_arready,
    output logic [AXIL_DATA_BITS-1:0]   o_axil_rdata,
    output logic [1:0]                  o_axil_rresp,
    output logic                        o_axil_rvalid,
    input  logic                        i_axil_rready
);

    capture_cfg_t                 cfg;
    logic                         arm_pulse;
    logic [CAPTURE_ADDR_BITS-1:0] read_index;
    capture_status_t              status;
    xgmii_word_t                  entry;
    logic                         trig_hit;

    axil_capture_regs u_regs (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_axil_awaddr  (i_axil_awaddr),
        .i_axil_awvalid (i_axil_awvalid),
        .o_axil_awready (o_axil_awready),
        .i_axil_wdata   (i_axil_wdata),
        .i_axil_wstrb   (i_axil_wstrb),
        .i_axil_wvalid  (i_axil_wvalid),
        .o_axil_wready  (o_axil_wready),
        .o_axil_bresp   (o_axil_bresp),
        .o_axil_bvalid  (o_axil_bvalid),
        .i_axil_bready  (i_axil_bready),
        .i_axil_araddr  (i_axil_araddr),
        .i_axil_arvalid (i_axil_arvalid),
        .o_axil_arready (o_axil_arready),
        .o_axil_rdata   (o_axil_rdata),
        .o_axil_rresp   (o_axil_rresp),
        .o_axil_rvalid  (o_axil_rvalid),
        .i_axil_rready  (i_axil_rready),
        .o_cfg          (cfg),
        .o_arm          (arm_pulse),
        .o_read_index   (read_index),
        .i_status       (status),
        .i_entry        (entry)
    );

    // Sees the raw stream, one cycle ahead of the capture stage
    trigger_match u_trigger (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_word      (i_rx_word),
        .i_valid     (i_rx_valid),
        .i_trig_char (cfg.trig_char),
        .o_hit       (trig_hit)
    );

    capture_control u_control (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_arm         (arm_pulse),
        .i_trig_enable (cfg.trig_enable),
        .i_trig_hit    (trig_hit),
        .i_word        (i_rx_word),
        .i_valid       (i_rx_valid),
        .i_read_index  (read_index),
        .o_entry       (entry),
        .o_status      (status)
    );

endmodule

//--- verification/capture_assertions.sv
// Bound into the capture top so it sees both the AXI ports and the internal write enable
`timescale 1ns/1ps

module capture_assertions
    import capture_pkg::*;
(
    input  logic            i_clock,
    input  logic            i_reset,
    input  logic            i_write_enable,
    input  logic            i_arm,
    input  capture_status_t i_status,
    input  logic            i_bvalid,
    input  logic            i_bready,
    input  logic            i_rvalid,
    input  logic            i_rready
);

    int failures = 0;  // Read by the testbench at the end of the run

    assert property (@(posedge i_clock) disable iff (i_reset) i_status.full |-> !i_write_enable)
    else
    begin
        $error("Memory written while the capture is full");
        failures++;
    end

    // Only an arm pulse may move the count once full
    assert property (@(posedge i_clock) disable iff (i_reset)
                     (i_status.full && !i_arm) |=> $stable(i_status.count))
    else
    begin
        $error("Count changed while the capture is full");
        failures++;
    end

    assert property (@(posedge i_clock) disable iff (i_reset)
                     $rose(i_status.full) |-> (i_status.count == CAPTURE_DEPTH))
    else
    begin
        $error("Full rose before every entry was written");
        failures++;
    end

    assert property (@(posedge i_clock) disable iff (i_reset)
                     (i_bvalid && !i_bready) |=> i_bvalid)
    else
    begin
        $error("Write response dropped before bready");
        failures++;
    end

    assert property (@(posedge i_clock) disable iff (i_reset)
                     (i_rvalid && !i_rready) |=> i_rvalid)
    else
    begin
        $error("Read data dropped before rready");
        failures++;
    end

endmodule

bind xgmii_capture_top capture_assertions u_assertions (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_write_enable (u_control.write_enable),
    .i_arm          (arm_pulse),
    .i_status       (status),
    .i_bvalid       (o_axil_bvalid),
    .i_bready       (i_axil_bready),
    .i_rvalid       (o_axil_rvalid),
    .i_rready       (i_axil_rready)
);

//--- verification/tb_xgmii_capture.sv
// Drives the stream tap and AXI4-Lite of the capture top; expects the bound assertion module inside the DUT
`timescale 1ns/1ps

module tb_xgmii_capture
    import capture_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 200;  // Longest wait allowed for any handshake or poll

    logic                        clock;
    logic                        reset;
    xgmii_word_t                 rx_word;
    logic                        rx_valid;
    logic [AXIL_ADDR_BITS-1:0]   axil_awaddr;
    logic                        axil_awvalid;
    logic                        axil_awready;
    logic [AXIL_DATA_BITS-1:0]   axil_wdata;
    logic [AXIL_DATA_BITS/8-1:0] axil_wstrb;
    logic                        axil_wvalid;
    logic                        axil_wready;
    logic [1:0]                  axil_bresp;
    logic                        axil_bvalid;
    logic                        axil_bready;
    logic [AXIL_ADDR_BITS-1:0]   axil_araddr;
    logic                        axil_arvalid;
    logic                        axil_arready;
    logic [AXIL_DATA_BITS-1:0]   axil_rdata;
    logic [1:0]                  axil_rresp;
    logic                        axil_rvalid;
    logic                        axil_rready;

    logic [31:0] lcg_state = 32'h6a82_198f;
    xgmii_word_t sent_words [$];  // Valid words seen by the tap since the last arm
    int          checks     = 0;
    int          errors     = 0;
    int          mark       = 0;  // Error count when the current test began
    int          passed     = 0;
    int          failed     = 0;

    xgmii_capture_top u_xgmii_capture_top (
        .i_clock        (clock),
        .i_reset        (reset),
        .i_rx_word      (rx_word),
        .i_rx_valid     (rx_valid),
        .i_axil_awaddr  (axil_awaddr),
        .i_axil_awvalid (axil_awvalid),
        .o_axil_awready (axil_awready),
        .i_axil_wdata   (axil_wdata),
        .i_axil_wstrb   (axil_wstrb),
        .i_axil_wvalid  (axil_wvalid),
        .o_axil_wready  (axil_wready),
        .o_axil_bresp   (axil_bresp),
        .o_axil_bvalid  (axil_bvalid),
        .i_axil_bready  (axil_bready),
        .i_axil_araddr  (axil_araddr),
        .i_axil_arvalid (axil_arvalid),
        .o_axil_arready (axil_arready),
        .o_axil_rdata   (axil_rdata),
        .o_axil_rresp   (axil_rresp),
        .o_axil_rvalid  (axil_rvalid),
        .i_axil_rready  (axil_rready)
    );

    initial
    begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic capture_status_t make_status(input logic armed, input logic full,
                                                    input int count);
        capture_status_t status;
        status.armed = armed;
        status.full  = full;
        status.count = count[CAPTURE_ADDR_BITS:0];
        return status;
    endfunction

    // Immediate mode keeps the first valid words, triggered mode starts at the matching word
    function automatic xgmii_word_t expected_entry(input xgmii_word_t sent [$], input int index,
                                                   input logic trig_enable,
                                                   input logic [7:0] trig_char);
        int start;
        start = 0;
        if (trig_enable)
        begin
            while (start < sent.size() &&
                   !(sent[start].ctrl[0] && sent[start].data[7:0] == trig_char))
            begin
                start++;
            end
        end
        if (start + index < sent.size())
        begin
            return sent[start + index];
        end
        return 'x;  // Too few words sent, so no entry can match
    endfunction

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic check_word(input string name, input xgmii_word_t expected,
                              input xgmii_word_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_status(input string name, input capture_status_t expected,
                                input capture_status_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] expected,
                              input logic [1:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == mark)
        begin
            passed++;
            $display("Test %s: ok", name);
        end
        else
        begin
            failed++;
            $display("Test %s: failed with %0d errors", name, errors - mark);
        end
        mark = errors;
    endtask

    task automatic axil_write(input logic [AXIL_ADDR_BITS-1:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int cycles;
        cycles = 0;
        @(negedge clock);
        axil_awaddr  = addr;
        axil_wdata   = data;
        axil_wstrb   = '1;
        axil_awvalid = 1'b1;
        axil_wvalid  = 1'b1;
        @(posedge clock);
        while (!(axil_awready && axil_wready))  // Ready as the slave sees it at the edge
        begin
            if (cycles == TIMEOUT_CYCLES)
            begin
                report_timeout("the AXI write address and data ready");
            end
            cycles++;
            @(posedge clock);
        end
        @(negedge clock);
        axil_awvalid = 1'b0;
        axil_wvalid  = 1'b0;
        cycles       = 0;
        while (!axil_bvalid)
        begin
            if (cycles == TIMEOUT_CYCLES)
            begin
                report_timeout("the AXI write response");
            end
            cycles++;
            @(negedge clock);
        end
        resp = axil_bresp;
        @(negedge clock);
        axil_bready = 1'b1;  // One cycle late so the response has to wait
        @(negedge clock);
        axil_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [AXIL_ADDR_BITS-1:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int cycles;
        cycles = 0;
        @(negedge clock);
        axil_araddr  = addr;
        axil_arvalid = 1'b1;
        @(posedge clock);
        while (!axil_arready)
        begin
            if (cycles == TIMEOUT_CYCLES)
            begin
                report_timeout("the AXI read address ready");
            end
            cycles++;
            @(posedge clock);
        end
        @(negedge clock);
        axil_arvalid = 1'b0;
        cycles       = 0;
        while (!axil_rvalid)
        begin
            if (cycles == TIMEOUT_CYCLES)
            begin
                report_timeout("the AXI read data");
            end
            cycles++;
            @(negedge clock);
        end
        data = axil_rdata;
        resp = axil_rresp;
        @(negedge clock);
        axil_rready = 1'b1;  // Read data must hold until this point
        @(negedge clock);
        axil_rready = 1'b0;
    endtask

    task automatic send_word(input xgmii_word_t word);
        @(negedge clock);
        rx_word  = word;
        rx_valid = 1'b1;
        sent_words.push_back(word);
    endtask

    task automatic stream_idle();
        @(negedge clock);
        rx_valid = 1'b0;
    endtask

    // Random words with an occasional invalid cycle in between
    task automatic send_random_words(input int count);
        xgmii_word_t word;
        for (int i = 0; i < count; i++)
        begin
            lcg_state = lcg_next(lcg_state);
            word.data[31:0] = lcg_state;
            lcg_state = lcg_next(lcg_state);
            word.data[63:32] = lcg_state;
            lcg_state = lcg_next(lcg_state);
            word.ctrl = lcg_state[31:24];
            if (lcg_state[9:8] == 2'b00)
            begin
                stream_idle();
            end
            send_word(word);
        end
        stream_idle();
    endtask

    task automatic wait_full(output capture_status_t status);
        logic [31:0] data;
        logic [1:0]  resp;
        int          polls;
        polls  = 0;
        status = '0;
        while (!status.full)
        begin
            if (polls == TIMEOUT_CYCLES)
            begin
                report_timeout("the capture to fill");
            end
            axil_read(REG_STATUS, data, resp);
            status = data[$bits(capture_status_t)-1:0];
            polls++;
        end
    endtask

    // Reads every entry back through the index register and the three windows
    task automatic compare_capture(input string name, input logic trig_enable,
                                   input logic [7:0] trig_char);
        xgmii_word_t actual;
        logic [31:0] data;
        logic [1:0]  resp;
        for (int i = 0; i < CAPTURE_DEPTH; i++)
        begin
            axil_write(REG_INDEX, i, resp);
            axil_read(REG_DATA_LO, data, resp);
            actual.data[31:0] = data;
            axil_read(REG_DATA_HI, data, resp);
            actual.data[63:32] = data;
            axil_read(REG_CTRL_RD, data, resp);
            actual.ctrl = data[CTRL_BITS-1:0];
            check_word($sformatf("%s entry %0d", name, i),
                       expected_entry(sent_words, i, trig_enable, trig_char), actual);
        end
    endtask

    initial
    begin
        capture_status_t status;
        logic [31:0]     data;
        logic [1:0]      resp;
        int              assert_failures;
        reset        = 1'b1;
        rx_word      = '0;
        rx_valid     = 1'b0;
        axil_awaddr  = '0;
        axil_awvalid = 1'b0;
        axil_wdata   = '0;
        axil_wstrb   = '0;
        axil_wvalid  = 1'b0;
        axil_bready  = 1'b0;
        axil_araddr  = '0;
        axil_arvalid = 1'b0;
        axil_rready  = 1'b0;
        repeat (10) @(negedge clock);
        reset = 1'b0;

        axil_read(REG_STATUS, data, resp);
        check_status("reset status", make_status(0, 0, 0), data[7:0]);
        check_resp("reset status resp", RESP_OKAY, resp);
        finish_test("reset_status");

        axil_write(REG_CTRL, 32'h1, resp);
        sent_words.delete();
        send_random_words(45);
        wait_full(status);
        check_status("immediate status", make_status(0, 1, CAPTURE_DEPTH), status);
        compare_capture("immediate", 1'b0, 8'h00);
        finish_test("immediate_capture");

        axil_write(REG_TRIG, 32'hFB, resp);
        axil_write(REG_CTRL, 32'h3, resp);  // Arm with the trigger enabled
        sent_words.delete();
        for (int i = 0; i < 6; i++)
        begin
            send_word('{data: 64'h0707_0707_0707_0707, ctrl: 8'hFF});
        end
        stream_idle();
        axil_read(REG_STATUS, data, resp);
        check_status("waiting status", make_status(1, 0, 0), data[7:0]);
        send_word('{data: 64'h5555_5555_5555_55FB, ctrl: 8'h01});
        send_random_words(40);
        wait_full(status);
        check_status("triggered status", make_status(0, 1, CAPTURE_DEPTH), status);
        compare_capture("triggered", 1'b1, 8'hFB);
        finish_test("triggered_capture");

        axil_write(REG_CTRL, 32'h1, resp);
        axil_read(REG_STATUS, data, resp);
        check_status("rearm status", make_status(1, 0, 0), data[7:0]);
        sent_words.delete();
        send_random_words(40);
        wait_full(status);
        compare_capture("rearm", 1'b0, 8'h00);
        finish_test("rearm_capture");

        axil_write(REG_TRIG, 32'h5A, resp);
        axil_read(REG_TRIG, data, resp);
        check_value("trig readback", 32'h5A, data);
        axil_write(REG_INDEX, 32'h13, resp);
        axil_read(REG_INDEX, data, resp);
        check_value("index readback", 32'h13, data);
        axil_write(8'h40, 32'h0, resp);
        check_resp("bad write resp", RESP_SLVERR, resp);
        axil_read(8'h40, data, resp);
        check_resp("bad read resp", RESP_SLVERR, resp);
        finish_test("registers_and_errors");

        assert_failures = u_xgmii_capture_top.u_assertions.failures;
        $display("Tests passed %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 passed, failed, checks, errors, assert_failures);
        if (errors == 0 && assert_failures == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- flist.f
hw/capture_pkg.sv
hw/capture_bram.sv
hw/trigger_match.sv
hw/capture_control.sv
hw/axil_capture_regs.sv
hw/xgmii_capture_top.sv
verification/capture_assertions.sv
verification/tb_xgmii_capture.sv
